// ==== common/pong_macros.svh ====
`ifndef PONG_MACROS_SVH
`define PONG_MACROS_SVH

// Ball motion.
`define BASE_PERIOD  270000   // Step period at speed 1.
`define X_STEP       10
`define Y_RESET      220
`define VY_RESET     (-3)     // Vertical speed of a served ball.
`define X_ENTRY      20       // Where a received ball shows up.

// Screen limits picked by upscale.
`define X_RIGHT(up)  ((up) ? 620 : 300)
`define Y_MAX(up)    ((up) ? 479 : 239)

// Paddle.
`define PADDLE_X     20
`define PADDLE_H     40
`define SPEED_WINDOW 64       // Cycles between paddle samples.
`define MIN_SPEED    2

// Register map.
`define REG_CTRL       6'h00
`define REG_IN_Y       6'h04
`define REG_IN_VY      6'h08
`define REG_IN_GRAVITY 6'h0C
`define REG_IN_PERIOD  6'h10
`define REG_OUT_Y      6'h14
`define REG_OUT_VY     6'h18
`define REG_OUT_GRAVITY 6'h1C
`define REG_OUT_PERIOD 6'h20

`endif

// ==== common/pong_pkg.sv ====
`default_nettype none

package pong_pkg;

    // Ball as it crosses from one board to the other.
    typedef struct packed {
        logic [9:0]        y;
        logic signed [7:0] vy;
        logic [1:0]        gravity;   // Phase of the every-fourth-step pull.
        logic [19:0]       period;
    } ball_state_t;

    typedef enum logic [2:0] {
        IDLE          = 3'd0,
        RUNNING_RIGHT = 3'd1,
        RUNNING_LEFT  = 3'd2,
        STOP          = 3'd3,
        SEND_BALL     = 3'd4,
        WAIT          = 3'd5
    } game_state_t;

    // AXI4-Lite master to slave.
    typedef struct packed {
        logic [5:0]  awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [5:0]  araddr;
        logic        arvalid;
        logic        rready;
    } axil_req_t;

    // AXI4-Lite slave to master.
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic [1:0]  bresp;
        logic        bvalid;
        logic        arready;
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        rvalid;
    } axil_rsp_t;

endpackage

`default_nettype wire

// ==== compile.f ====
+incdir+common
common/pong_pkg.sv
logic/ball_link_regs.sv
logic/paddle_tracker.sv
game/game_controller.sv
logic/pong_board_top.sv
testbench/pong_board_tb.sv

// ==== game/game_controller.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "pong_macros.svh"

module game_controller #(
    parameter int unsigned base_period = `BASE_PERIOD
) (
    input  wire                    clk_25MHZ,
    input  wire                    reset,
    input  wire                    game_start,
    input  wire                    upscale,
    input  wire                    collision,
    input  wire [9:0]              estimated_speed,
    input  wire pong_pkg::ball_state_t incoming_ball,
    input  wire                    ball_pending,
    output logic                   ball_taken,
    output pong_pkg::ball_state_t  outgoing_ball,
    output pong_pkg::game_state_t  state,
    output logic [9:0]             ball_x,
    output logic [9:0]             ball_y,
    output logic                   moving_right,
    output logic                   game_over,
    output logic                   ball_sent,
    output logic                   idle
);

    localparam logic [19:0] base_period_w = 20'(base_period);

    pong_pkg::game_state_t state_next;

    logic [9:0]        x_next;
    logic [9:0]        y_next;
    logic signed [7:0] vy;
    logic signed [7:0] vy_next;
    logic [1:0]        grav;
    logic [1:0]        grav_next;
    logic [19:0]       period;
    logic [19:0]       period_next;
    logic [20:0]       count;
    logic [20:0]       count_next;

    logic [9:0]        x_limit;
    logic [9:0]        y_max;
    logic [9:0]        safe_speed;
    logic [19:0]       return_period;

    logic              step;
    logic signed [7:0] vy_grav;
    logic signed [11:0] y_sum;
    logic [9:0]        step_y;
    logic signed [7:0] step_vy;

    assign x_limit = 10'(`X_RIGHT(upscale));
    assign y_max   = 10'(`Y_MAX(upscale));

    // Faster paddle gives a shorter period.
    assign safe_speed    = (estimated_speed < 10'(`MIN_SPEED)) ? 10'(`MIN_SPEED) : estimated_speed;
    assign return_period = base_period_w / {10'd0, safe_speed};

    assign moving_right = (state == pong_pkg::RUNNING_RIGHT);
    assign game_over    = (state == pong_pkg::STOP);
    assign ball_sent    = (state == pong_pkg::SEND_BALL);
    assign idle         = (state == pong_pkg::IDLE);

    // Vertical part of one step, shared by both directions.
    always_comb begin
        step    = (count > {1'b0, period});
        vy_grav = (grav == 2'd3) ? vy + 8'sd1 : vy;
        y_sum   = $signed({2'b00, ball_y}) + $signed({{4{vy[7]}}, vy});
        if (y_sum < 0) begin
            step_y  = 10'd0;
            step_vy = -vy_grav;
        end else if (y_sum > $signed({2'b00, y_max})) begin
            step_y  = y_max;
            step_vy = -vy_grav;
        end else begin
            step_y  = y_sum[9:0];
            step_vy = vy_grav;
        end
    end

    always_comb begin
        state_next  = state;
        x_next      = ball_x;
        y_next      = ball_y;
        vy_next     = vy;
        grav_next   = grav;
        period_next = period;
        count_next  = count;
        ball_taken  = 1'b0;

        case (state)
            pong_pkg::IDLE: begin
                x_next      = 10'd0;
                y_next      = 10'(`Y_RESET);
                vy_next     = 8'(`VY_RESET);
                grav_next   = 2'd0;
                period_next = base_period_w;
                count_next  = 21'd0;
                if (game_start) begin
                    state_next = pong_pkg::RUNNING_RIGHT;
                end else if (ball_pending) begin
                    ball_taken  = 1'b1;
                    x_next      = 10'(`X_ENTRY);
                    y_next      = incoming_ball.y;
                    vy_next     = incoming_ball.vy;
                    grav_next   = incoming_ball.gravity;
                    period_next = (incoming_ball.period == 20'd0) ? base_period_w
                                                                  : incoming_ball.period;
                    state_next  = pong_pkg::WAIT;
                end
            end

            pong_pkg::WAIT: begin
                if (!ball_pending) state_next = pong_pkg::RUNNING_LEFT;  // Link released.
            end

            pong_pkg::RUNNING_RIGHT: begin
                if (ball_x >= x_limit) begin
                    state_next = pong_pkg::SEND_BALL;
                end else if (step) begin
                    x_next     = ball_x + 10'(`X_STEP);
                    y_next     = step_y;
                    vy_next    = step_vy;
                    grav_next  = grav + 2'd1;
                    count_next = 21'd0;
                end else begin
                    count_next = count + 21'd1;
                end
            end

            pong_pkg::RUNNING_LEFT: begin
                if (collision) begin
                    state_next  = pong_pkg::RUNNING_RIGHT;
                    period_next = return_period;
                    count_next  = 21'd0;
                end else if (ball_x == 10'd0) begin
                    state_next = pong_pkg::STOP;    // Missed.
                end else if (step) begin
                    x_next     = (ball_x > 10'(`X_STEP)) ? ball_x - 10'(`X_STEP) : 10'd0;
                    y_next     = step_y;
                    vy_next    = step_vy;
                    grav_next  = grav + 2'd1;
                    count_next = 21'd0;
                end else begin
                    count_next = count + 21'd1;
                end
            end

            pong_pkg::STOP, pong_pkg::SEND_BALL: begin
                if (game_start) state_next = pong_pkg::IDLE;
            end

            default: state_next = pong_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            state  <= pong_pkg::IDLE;
            ball_x <= 10'd0;
            ball_y <= 10'(`Y_RESET);
            vy     <= 8'(`VY_RESET);
            grav   <= 2'd0;
            period <= base_period_w;
            count  <= 21'd0;
        end else begin
            state  <= state_next;
            ball_x <= x_next;
            ball_y <= y_next;
            vy     <= vy_next;
            grav   <= grav_next;
            period <= period_next;
            count  <= count_next;
        end
    end

    // Snapshot of the ball as it leaves the right edge.
    always_ff @(posedge clk_25MHZ) begin
        if (state == pong_pkg::RUNNING_RIGHT && state_next == pong_pkg::SEND_BALL) begin
            outgoing_ball <= '{y: ball_y, vy: vy, gravity: grav, period: period};
        end
    end

endmodule

`default_nettype wire

// ==== logic/ball_link_regs.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "pong_macros.svh"

module ball_link_regs (
    input  wire                        clk_25MHZ,
    input  wire                        reset,
    input  wire pong_pkg::axil_req_t   s_axil_req,
    output pong_pkg::axil_rsp_t        s_axil_rsp,
    input  wire pong_pkg::ball_state_t outgoing_ball,
    input  wire pong_pkg::game_state_t state,
    input  wire                        ball_taken,
    output pong_pkg::ball_state_t      incoming_ball,
    output logic                       ball_pending
);

    logic        awready, wready, bvalid;
    logic        arready, rvalid;
    logic        aw_done, w_done;
    logic        aw_hs, w_hs, b_hs, ar_hs, r_hs;
    logic        have_aw, have_w, wr_en;
    logic [5:0]  awaddr_q, wr_addr;
    logic [31:0] wdata_q, wr_data;
    logic [3:0]  wstrb_q, wr_strb;
    logic [31:0] rd_word, rdata_q;

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                                input logic [31:0] new_val,
                                                input logic [3:0]  strb);
        logic [31:0] result;
        result = old_val;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) result[8*i +: 8] = new_val[8*i +: 8];
        end
        return result;
    endfunction

    assign aw_hs = s_axil_req.awvalid && awready;
    assign w_hs  = s_axil_req.wvalid && wready;
    assign b_hs  = bvalid && s_axil_req.bready;
    assign ar_hs = s_axil_req.arvalid && arready;
    assign r_hs  = rvalid && s_axil_req.rready;

    // Address and data may arrive in either order.
    assign have_aw = aw_done || aw_hs;
    assign have_w  = w_done || w_hs;
    assign wr_en   = have_aw && have_w;
    assign wr_addr = aw_done ? awaddr_q : s_axil_req.awaddr;
    assign wr_data = w_done ? wdata_q : s_axil_req.wdata;
    assign wr_strb = w_done ? wstrb_q : s_axil_req.wstrb;

    always_comb begin
        case (s_axil_req.araddr)
            `REG_CTRL:        rd_word = {25'd0, state, 3'd0, ball_pending};
            `REG_IN_Y:        rd_word = {22'd0, incoming_ball.y};
            `REG_IN_VY:       rd_word = {24'd0, incoming_ball.vy};
            `REG_IN_GRAVITY:  rd_word = {30'd0, incoming_ball.gravity};
            `REG_IN_PERIOD:   rd_word = {12'd0, incoming_ball.period};
            `REG_OUT_Y:       rd_word = {22'd0, outgoing_ball.y};
            `REG_OUT_VY:      rd_word = {24'd0, outgoing_ball.vy};
            `REG_OUT_GRAVITY: rd_word = {30'd0, outgoing_ball.gravity};
            `REG_OUT_PERIOD:  rd_word = {12'd0, outgoing_ball.period};
            default:          rd_word = 32'd0;
        endcase
    end

    always_comb begin
        s_axil_rsp         = '0;   // OKAY on both responses.
        s_axil_rsp.awready = awready;
        s_axil_rsp.wready  = wready;
        s_axil_rsp.bvalid  = bvalid;
        s_axil_rsp.arready = arready;
        s_axil_rsp.rvalid  = rvalid;
        s_axil_rsp.rdata   = rdata_q;
    end

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            awready      <= 1'b0;
            wready       <= 1'b0;
            bvalid       <= 1'b0;
            arready      <= 1'b0;
            rvalid       <= 1'b0;
            aw_done      <= 1'b0;
            w_done       <= 1'b0;
            ball_pending <= 1'b0;
        end else begin
            // One-cycle readies held off while a response waits.
            awready <= s_axil_req.awvalid && !awready && !aw_done && !bvalid;
            wready  <= s_axil_req.wvalid && !wready && !w_done && !bvalid;
            arready <= s_axil_req.arvalid && !arready && !rvalid;

            if (wr_en) begin
                aw_done <= 1'b0;
                w_done  <= 1'b0;
                bvalid  <= 1'b1;
            end else begin
                if (aw_hs) aw_done <= 1'b1;
                if (w_hs) w_done <= 1'b1;
                if (b_hs) bvalid <= 1'b0;
            end

            if (ar_hs) begin
                rvalid <= 1'b1;
            end else if (r_hs) begin
                rvalid <= 1'b0;
            end

            if (ball_taken) ball_pending <= 1'b0;
            if (wr_en && wr_addr == `REG_CTRL && wr_strb[0] && wr_data[0]) begin
                ball_pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_25MHZ) begin
        if (aw_hs) awaddr_q <= s_axil_req.awaddr;
        if (w_hs) begin
            wdata_q <= s_axil_req.wdata;
            wstrb_q <= s_axil_req.wstrb;
        end
        if (ar_hs) rdata_q <= rd_word;
        if (wr_en) begin
            case (wr_addr)
                `REG_IN_Y: incoming_ball.y <=
                    10'(merge_bytes({22'd0, incoming_ball.y}, wr_data, wr_strb));
                `REG_IN_VY: incoming_ball.vy <=
                    8'(merge_bytes({24'd0, incoming_ball.vy}, wr_data, wr_strb));
                `REG_IN_GRAVITY: incoming_ball.gravity <=
                    2'(merge_bytes({30'd0, incoming_ball.gravity}, wr_data, wr_strb));
                `REG_IN_PERIOD: incoming_ball.period <=
                    20'(merge_bytes({12'd0, incoming_ball.period}, wr_data, wr_strb));
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/paddle_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "pong_macros.svh"

module paddle_tracker (
    input  wire        clk_25MHZ,
    input  wire        reset,
    input  wire [9:0]  paddle_y,
    input  wire [9:0]  ball_x,
    input  wire [9:0]  ball_y,
    output logic       collision,
    output logic [9:0] estimated_speed
);

    localparam int window_bits = $clog2(`SPEED_WINDOW);

    logic [window_bits-1:0] window_count;
    logic [9:0]             last_y;
    logic                   have_sample;
    logic [10:0]            paddle_bottom;
    logic                   hit;
    logic                   window_end;

    assign paddle_bottom = {1'b0, paddle_y} + 11'(`PADDLE_H);

    // Ball at the paddle column and inside its span.
    assign hit = (ball_x <= 10'(`PADDLE_X))
              && (ball_y >= paddle_y)
              && ({1'b0, ball_y} <= paddle_bottom);

    assign window_end = (window_count == window_bits'(`SPEED_WINDOW - 1));

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            collision       <= 1'b0;
            window_count    <= '0;
            last_y          <= 10'd0;
            have_sample     <= 1'b0;
            estimated_speed <= 10'd0;
        end else begin
            collision    <= hit;
            window_count <= window_count + 1'b1;
            if (window_end) begin
                last_y      <= paddle_y;
                have_sample <= 1'b1;
                // First window only takes a reference sample.
                if (have_sample) begin
                    estimated_speed <= (paddle_y > last_y) ? paddle_y - last_y
                                                           : last_y - paddle_y;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/pong_board_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "pong_macros.svh"

module pong_board_top #(
    parameter int unsigned base_period = `BASE_PERIOD
) (
    input  wire                      clk_25MHZ,
    input  wire                      reset,
    input  wire                      game_start,
    input  wire                      upscale,
    input  wire [9:0]                paddle_y,
    input  wire pong_pkg::axil_req_t s_axil_req,
    output pong_pkg::axil_rsp_t      s_axil_rsp,
    output logic [9:0]               ball_x,
    output logic [9:0]               ball_y,
    output logic                     moving_right,
    output logic                     game_over,
    output logic                     ball_sent,
    output logic                     idle
);

    pong_pkg::ball_state_t incoming_ball;
    pong_pkg::ball_state_t outgoing_ball;
    pong_pkg::game_state_t state;
    logic                  ball_pending;
    logic                  ball_taken;
    logic                  collision;
    logic [9:0]            estimated_speed;

    ball_link_regs u_regs (
        .clk_25MHZ    (clk_25MHZ),
        .reset        (reset),
        .s_axil_req   (s_axil_req),
        .s_axil_rsp   (s_axil_rsp),
        .outgoing_ball(outgoing_ball),
        .state        (state),
        .ball_taken   (ball_taken),
        .incoming_ball(incoming_ball),
        .ball_pending (ball_pending)
    );

    paddle_tracker u_tracker (
        .clk_25MHZ      (clk_25MHZ),
        .reset          (reset),
        .paddle_y       (paddle_y),
        .ball_x         (ball_x),
        .ball_y         (ball_y),
        .collision      (collision),
        .estimated_speed(estimated_speed)
    );

    game_controller #(
        .base_period(base_period)
    ) u_game (
        .clk_25MHZ      (clk_25MHZ),
        .reset          (reset),
        .game_start     (game_start),
        .upscale        (upscale),
        .collision      (collision),
        .estimated_speed(estimated_speed),
        .incoming_ball  (incoming_ball),
        .ball_pending   (ball_pending),
        .ball_taken     (ball_taken),
        .outgoing_ball  (outgoing_ball),
        .state          (state),
        .ball_x         (ball_x),
        .ball_y         (ball_y),
        .moving_right   (moving_right),
        .game_over      (game_over),
        .ball_sent      (ball_sent),
        .idle           (idle)
    );

endmodule

`default_nettype wire

// ==== testbench/pong_board_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "pong_macros.svh"

module pong_board_tb;

    localparam int base      = 20;
    localparam int rec_words = 13;
    localparam int num_tests = 5;

    logic                clk_25MHZ;
    logic                reset;
    logic                game_start;
    logic                upscale;
    logic [9:0]          paddle_y;
    pong_pkg::axil_req_t req;
    pong_pkg::axil_rsp_t rsp;
    logic [9:0]          ball_x;
    logic [9:0]          ball_y;
    logic                moving_right;
    logic                game_over;
    logic                ball_sent;
    logic                idle;

    logic [31:0] tdata [0:num_tests*rec_words-1];
    string       cur_test;
    int          errors;
    int          errors_start;
    int          passed;
    int          failed;
    int          watchdog_cycles;
    logic [31:0] rnd_state;

    // Reference ball.
    int mx, my, mvy, mg, mperiod, mdir;
    int steps;

    pong_board_top #(
        .base_period(base)
    ) uut (
        .clk_25MHZ   (clk_25MHZ),
        .reset       (reset),
        .game_start  (game_start),
        .upscale     (upscale),
        .paddle_y    (paddle_y),
        .s_axil_req  (req),
        .s_axil_rsp  (rsp),
        .ball_x      (ball_x),
        .ball_y      (ball_y),
        .moving_right(moving_right),
        .game_over   (game_over),
        .ball_sent   (ball_sent),
        .idle        (idle)
    );

    initial begin
        clk_25MHZ = 1'b0;
        forever #20 clk_25MHZ = ~clk_25MHZ;
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk_25MHZ);
        $display("Timeout: tests did not finish within %0d cycles", watchdog_cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("ERROR test %s, %s: expected 0x%0h, actual 0x%0h",
                     cur_test, what, expected, actual);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("Test %s: %s", cur_test, msg);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk_25MHZ);
        #2;
    endtask

    task automatic axi_write(input logic [5:0] addr, input logic [31:0] data);
        logic aw_ok;
        logic w_ok;
        aw_ok = 1'b0;
        w_ok  = 1'b0;
        @(posedge clk_25MHZ);
        #2;
        req.awaddr  = addr;
        req.awvalid = 1'b1;
        req.wdata   = data;
        req.wstrb   = 4'hF;
        req.wvalid  = 1'b1;
        while (!(aw_ok && w_ok)) begin
            @(negedge clk_25MHZ);
            if (req.awvalid && rsp.awready) aw_ok = 1'b1;
            if (req.wvalid && rsp.wready) w_ok = 1'b1;
            @(posedge clk_25MHZ);
            #2;
            if (aw_ok) req.awvalid = 1'b0;
            if (w_ok) req.wvalid = 1'b0;
        end
        req.bready = 1'b1;
        @(negedge clk_25MHZ);
        while (!rsp.bvalid) @(negedge clk_25MHZ);
        check_value("write response", 32'd0, rsp.bresp);
        @(posedge clk_25MHZ);
        #2;
        req.bready = 1'b0;
    endtask

    task automatic axi_read(input logic [5:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        @(posedge clk_25MHZ);
        #2;
        req.araddr  = addr;
        req.arvalid = 1'b1;
        req.rready  = 1'b1;
        @(negedge clk_25MHZ);
        while (!rsp.arready) @(negedge clk_25MHZ);
        @(posedge clk_25MHZ);
        #2;
        req.arvalid = 1'b0;
        @(negedge clk_25MHZ);
        while (!rsp.rvalid) @(negedge clk_25MHZ);
        data = rsp.rdata;
        resp = rsp.rresp;
        @(posedge clk_25MHZ);
        #2;
        req.rready = 1'b0;
    endtask

    task automatic read_check(input string what, input logic [5:0] addr,
                              input logic [31:0] expected);
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(addr, data, resp);
        check_value(what, expected, data);
        check_value({what, " response"}, 32'd0, resp);
    endtask

    task automatic pulse_start();
        @(posedge clk_25MHZ);
        #2;
        game_start = 1'b1;
        @(posedge clk_25MHZ);
        #2;
        game_start = 1'b0;
    endtask

    task automatic wait_idle();
        @(negedge clk_25MHZ);
        while (!idle) @(negedge clk_25MHZ);
    endtask

    // One ball step with gravity every fourth step and wall clamp.
    task automatic step_model();
        int ny;
        int gvy;
        int y_max;
        y_max = `Y_MAX(upscale);
        if (mdir > 0) mx = mx + `X_STEP;
        else mx = (mx > `X_STEP) ? mx - `X_STEP : 0;
        ny  = my + mvy;
        gvy = (mg == 3) ? mvy + 1 : mvy;
        if (ny < 0) begin
            my  = 0;
            mvy = -gvy;
        end else if (ny > y_max) begin
            my  = y_max;
            mvy = -gvy;
        end else begin
            my  = ny;
            mvy = gvy;
        end
        mg = (mg + 1) % 4;
    endtask

    task automatic follow_ball();
        int   cycles;
        int   dir_steps;
        logic done;
        cycles    = 0;
        dir_steps = 0;
        steps     = 0;
        done      = 1'b0;
        while (!done) begin
            @(negedge clk_25MHZ);
            cycles++;
            if (mdir < 0 && moving_right) begin
                if (!(mx <= `PADDLE_X && my >= paddle_y && my <= paddle_y + `PADDLE_H))
                    report_failure("ball turned right without touching the paddle");
                mdir      = 1;
                mperiod   = base / `MIN_SPEED;  // Still paddle.
                dir_steps = 0;
            end
            if (ball_x != mx) begin
                step_model();
                steps++;
                dir_steps++;
                check_value("ball_x", mx, ball_x);
                check_value("ball_y", my, ball_y);
                // First step of a run starts from a different count.
                if (dir_steps >= 2) check_value("cycles per step", mperiod + 2, cycles);
                cycles = 0;
            end
            done = ball_sent || game_over;
        end
    endtask

    task automatic finish_test();
        if (errors == errors_start) begin
            passed++;
            $display("Test %s: passed", cur_test);
        end else begin
            failed++;
            $display("Test %s: failed with %0d errors", cur_test, errors - errors_start);
        end
    endtask

    task automatic run_test(input int t);
        int          b;
        int          gap;
        int          outcome;
        logic [31:0] data;
        logic [1:0]  resp;
        b            = t * rec_words;
        cur_test     = $sformatf("%0d (%s)", t + 1, (tdata[b] == 1) ? "serve" : "receive");
        errors_start = errors;
        rnd_state    = xorshift(rnd_state);
        gap          = rnd_state % 8 + 1;
        @(posedge clk_25MHZ);
        #2;
        upscale  = tdata[b+1][0];
        paddle_y = tdata[b+2][9:0];
        wait_cycles(gap);
        if (tdata[b] == 1) begin
            mx      = 0;
            my      = `Y_RESET;
            mvy     = `VY_RESET;
            mg      = 0;
            mperiod = base;
            mdir    = 1;
            pulse_start();
            @(negedge clk_25MHZ);
            while (!moving_right) @(negedge clk_25MHZ);
        end else begin
            wait_cycles(2 * `SPEED_WINDOW + 4);  // Speed estimate settles at zero.
            axi_write(`REG_IN_Y, tdata[b+3]);
            axi_write(`REG_IN_VY, tdata[b+4]);
            axi_write(`REG_IN_GRAVITY, tdata[b+5]);
            axi_write(`REG_IN_PERIOD, tdata[b+6]);
            read_check("in_y", `REG_IN_Y, tdata[b+3]);
            read_check("in_vy", `REG_IN_VY, tdata[b+4]);
            read_check("in_gravity", `REG_IN_GRAVITY, tdata[b+5]);
            read_check("in_period", `REG_IN_PERIOD, tdata[b+6]);
            mx      = `X_ENTRY;
            my      = tdata[b+3];
            mvy     = $signed(tdata[b+4][7:0]);
            mg      = tdata[b+5];
            mperiod = (tdata[b+6] == 0) ? base : tdata[b+6];
            mdir    = -1;
            axi_write(`REG_CTRL, 32'd1);
            @(negedge clk_25MHZ);
            while (idle) @(negedge clk_25MHZ);
            check_value("entry x", `X_ENTRY, ball_x);
            check_value("entry y", tdata[b+3], ball_y);
        end
        follow_ball();
        outcome = ball_sent ? 1 : 2;
        check_value("outcome", tdata[b+8], outcome);
        check_value("steps", tdata[b+7], steps);
        check_value("final y", tdata[b+9], ball_y);
        axi_read(`REG_CTRL, data, resp);
        check_value("pending bit", 32'd0, data[0]);
        if (outcome == 1) begin
            read_check("out_y", `REG_OUT_Y, tdata[b+9]);
            read_check("out_vy", `REG_OUT_VY, tdata[b+10]);
            read_check("out_gravity", `REG_OUT_GRAVITY, tdata[b+11]);
            read_check("out_period", `REG_OUT_PERIOD, tdata[b+12]);
            check_value("model vy", tdata[b+10], mvy & 'hFF);
            check_value("model gravity", tdata[b+11], mg);
            check_value("model period", tdata[b+12], mperiod);
        end
        pulse_start();
        wait_idle();
        @(negedge clk_25MHZ);
        check_value("x after restart", 32'd0, ball_x);
        check_value("y after restart", `Y_RESET, ball_y);
        check_value("game_over after restart", 32'd0, game_over);
        check_value("ball_sent after restart", 32'd0, ball_sent);
        finish_test();
    endtask

    initial begin
        logic [31:0] data;
        logic [1:0]  resp;
        int          limit;
        reset           = 1'b1;
        game_start      = 1'b0;
        upscale         = 1'b0;
        paddle_y        = 10'd0;
        req             = '0;
        errors          = 0;
        passed          = 0;
        failed          = 0;
        rnd_state       = 32'd12542;
        watchdog_cycles = 0;
        $readmemh("testbench/pong_testdata.txt", tdata);

        // Steps times step length with margin, plus setup per test.
        limit = 1000;
        if (!$isunknown(tdata[0])) begin
            for (int t = 0; t < num_tests; t++) begin
                limit += (tdata[t*rec_words+7] + 4) * (base + 2) * 3 + 2 * `SPEED_WINDOW + 400;
            end
        end
        watchdog_cycles = limit;

        repeat (5) @(posedge clk_25MHZ);
        #2;
        reset = 1'b0;

        cur_test     = "reset";
        errors_start = errors;
        @(negedge clk_25MHZ);
        check_value("ball_x", 32'd0, ball_x);
        check_value("ball_y", `Y_RESET, ball_y);
        check_value("idle", 32'd1, idle);
        check_value("game_over", 32'd0, game_over);
        check_value("ball_sent", 32'd0, ball_sent);
        check_value("moving_right", 32'd0, moving_right);
        check_value("axi valid and ready", 32'd0,
                    {rsp.awready, rsp.wready, rsp.bvalid, rsp.arready, rsp.rvalid});
        axi_read(`REG_CTRL, data, resp);
        check_value("status state", 3'(pong_pkg::IDLE), data[6:4]);
        check_value("status pending", 32'd0, data[0]);
        finish_test();

        cur_test     = "unmapped";
        errors_start = errors;
        axi_write(6'h28, 32'hA5A5_5A5A);
        read_check("offset 0x28", 6'h28, 32'd0);
        read_check("offset 0x24", 6'h24, 32'd0);
        read_check("offset 0x3C", 6'h3C, 32'd0);
        finish_test();

        if ($isunknown(tdata[0])) begin
            errors++;
            failed++;
            $display("Test data: file testbench/pong_testdata.txt could not be read");
        end else begin
            for (int t = 0; t < num_tests; t++) run_test(t);
        end

        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 passed + failed, passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/pong_testdata.txt ====
// kind (1 serve, 2 receive), upscale, paddle_y, in_y, in_vy, in_gravity, in_period,
// expected steps, outcome (1 sent, 2 game over), final y, out_vy, out_gravity, out_period
1 0 0   0   0  0 0  1E 1 E4  04 2 14
1 1 0   0   0  0 0  3E 1 1DF F4 2 14
2 0 B4  C8  02 1 0  1C 1 C0  FF 1 0A
2 0 12C 5   F6 0 0  2  2 A   0  0 0
2 1 0   1D6 0F 3 5  2  2 1CF 0  0 0
